// File: source/sm83_isa_pkg.sv
`default_nettype none

package sm83_isa_pkg;

  // Two views of one opcode byte
  typedef struct packed {
    logic [1:0] x;
    logic [2:0] y;
    logic [2:0] z;
  } opcode_xyz_t;

  typedef struct packed {
    logic [1:0] x;
    logic [1:0] p;
    logic       q;
    logic [2:0] z;
  } opcode_xpqz_t;

  typedef union packed {
    opcode_xyz_t  xyz;
    opcode_xpqz_t xpqz;
  } opcode_u;

  // HL_MEM selects the byte at (HL), not a register
  typedef enum logic [2:0] {
    B      = 3'd0,
    C      = 3'd1,
    D      = 3'd2,
    E      = 3'd3,
    H      = 3'd4,
    L      = 3'd5,
    HL_MEM = 3'd6,
    A      = 3'd7
  } reg_idx_e;

  typedef enum logic [1:0] {
    BC = 2'd0,
    DE = 2'd1,
    HL = 2'd2,
    SP = 2'd3
  } pair_idx_e;

  typedef enum logic [3:0] {
    NOP, LD_R_R, LD_R_N, LD_R_HL, LD_HL_R, LD_HL_N,
    LD_RR_NN, INC_R, DEC_R, INC_RR, DEC_RR
  } op_class_e;

  typedef enum logic [1:0] {
    FETCH, OPERAND, MEMORY, EXECUTE
  } phase_e;

endpackage

`default_nettype wire

// File: source/sm83_bus_pkg.sv
`default_nettype none

package sm83_bus_pkg;

  typedef logic [15:0] addr_t;
  typedef logic [7:0]  data_t;

  // Clocks per M-cycle
  localparam int T_STATES = 4;

  typedef logic [1:0] tstate_t;

  localparam addr_t RESET_PC_DEFAULT = 16'h0100;

endpackage

`default_nettype wire

// File: source/regfile_if.sv
`default_nettype none

interface regfile_if ();

  sm83_isa_pkg::reg_idx_e  rd_sel_a;
  sm83_isa_pkg::reg_idx_e  rd_sel_b;
  sm83_bus_pkg::data_t     rd_data_a;
  sm83_bus_pkg::data_t     rd_data_b;
  sm83_bus_pkg::addr_t     hl;

  logic                    wr_en;
  sm83_isa_pkg::reg_idx_e  wr_sel;
  sm83_bus_pkg::data_t     wr_data;

  logic                    pair_wr_en;
  sm83_isa_pkg::pair_idx_e pair_sel;
  sm83_bus_pkg::addr_t     pair_wr_data;

  modport execute (
    output rd_sel_a, rd_sel_b, wr_en, wr_sel, wr_data, pair_wr_en, pair_sel, pair_wr_data,
    input  rd_data_a, rd_data_b, hl
  );

  modport regs (
    input  rd_sel_a, rd_sel_b, wr_en, wr_sel, wr_data, pair_wr_en, pair_sel, pair_wr_data,
    output rd_data_a, rd_data_b, hl
  );

endinterface

`default_nettype wire

// File: source/instr_sequencer.sv
`default_nettype none

module instr_sequencer #(
  parameter sm83_bus_pkg::addr_t RESET_PC = sm83_bus_pkg::RESET_PC_DEFAULT
) (
  input  wire logic                    i_clk,
  input  wire logic                    i_rst,
  input  wire sm83_bus_pkg::data_t     i_mem_rd_data,
  output sm83_isa_pkg::phase_e         o_phase,
  output sm83_bus_pkg::tstate_t        o_t_state,
  output sm83_isa_pkg::opcode_u        o_opcode,
  output sm83_isa_pkg::op_class_e      o_op_class,
  output sm83_bus_pkg::data_t          o_imm,
  output sm83_bus_pkg::addr_t          o_imm16,
  output sm83_bus_pkg::addr_t          o_fetch_addr
);

  localparam sm83_bus_pkg::tstate_t LAST_T = sm83_bus_pkg::tstate_t'(sm83_bus_pkg::T_STATES - 1);

  sm83_bus_pkg::tstate_t   t_state_q;
  sm83_isa_pkg::phase_e    phase_q;
  sm83_isa_pkg::phase_e    phase_d;
  sm83_isa_pkg::opcode_u   opcode_q;
  sm83_isa_pkg::opcode_u   fetched;
  sm83_isa_pkg::op_class_e op_class_q;
  sm83_isa_pkg::op_class_e decoded_class;
  sm83_bus_pkg::addr_t     pc_q;
  sm83_bus_pkg::data_t     imm_lo_q;
  sm83_bus_pkg::data_t     imm_hi_q;
  logic                    operand_idx_q;
  logic                    last_t;

  //////////////////////////////////////////////////////////////////////
  // Decode

  function automatic sm83_isa_pkg::op_class_e decode_class(sm83_isa_pkg::opcode_u op);
    sm83_isa_pkg::op_class_e cls;
    logic pair_is_sp;
    logic y_is_mem;
    logic z_is_mem;
    cls = sm83_isa_pkg::NOP;
    pair_is_sp = (op.xyz.y[2:1] == 2'b11);
    y_is_mem = (op.xyz.y == sm83_isa_pkg::HL_MEM);
    z_is_mem = (op.xyz.z == sm83_isa_pkg::HL_MEM);
    if (op.xyz.x == 2'd0) begin
      case (op.xyz.z)
        3'd1: if (!op.xyz.y[0] && !pair_is_sp) cls = sm83_isa_pkg::LD_RR_NN;
        3'd3: if (!pair_is_sp) cls = op.xyz.y[0] ? sm83_isa_pkg::DEC_RR : sm83_isa_pkg::INC_RR;
        3'd4: if (!y_is_mem) cls = sm83_isa_pkg::INC_R;
        3'd5: if (!y_is_mem) cls = sm83_isa_pkg::DEC_R;
        3'd6: cls = y_is_mem ? sm83_isa_pkg::LD_HL_N : sm83_isa_pkg::LD_R_N;
        default: ;
      endcase
    end else if (op.xyz.x == 2'd1) begin
      // 0x76 is HALT, not part of this core
      if (y_is_mem && z_is_mem) cls = sm83_isa_pkg::NOP;
      else if (z_is_mem) cls = sm83_isa_pkg::LD_R_HL;
      else if (y_is_mem) cls = sm83_isa_pkg::LD_HL_R;
      else cls = sm83_isa_pkg::LD_R_R;
    end
    return cls;
  endfunction

  function automatic logic [1:0] operand_count(sm83_isa_pkg::op_class_e cls);
    case (cls)
      sm83_isa_pkg::LD_R_N, sm83_isa_pkg::LD_HL_N: return 2'd1;
      sm83_isa_pkg::LD_RR_NN: return 2'd2;
      default: return 2'd0;
    endcase
  endfunction

  function automatic logic needs_memory(sm83_isa_pkg::op_class_e cls);
    return cls inside {sm83_isa_pkg::LD_R_HL, sm83_isa_pkg::LD_HL_R, sm83_isa_pkg::LD_HL_N};
  endfunction

  function automatic logic needs_execute(sm83_isa_pkg::op_class_e cls);
    return cls inside {sm83_isa_pkg::LD_R_R, sm83_isa_pkg::LD_R_N, sm83_isa_pkg::LD_R_HL,
                       sm83_isa_pkg::LD_RR_NN, sm83_isa_pkg::INC_R, sm83_isa_pkg::DEC_R,
                       sm83_isa_pkg::INC_RR, sm83_isa_pkg::DEC_RR};
  endfunction

  // Phase that follows the last operand byte
  function automatic sm83_isa_pkg::phase_e after_operands(sm83_isa_pkg::op_class_e cls);
    if (needs_memory(cls)) return sm83_isa_pkg::MEMORY;
    else if (needs_execute(cls)) return sm83_isa_pkg::EXECUTE;
    else return sm83_isa_pkg::FETCH;
  endfunction

  assign fetched = i_mem_rd_data;
  assign decoded_class = decode_class(fetched);
  assign last_t = (t_state_q == LAST_T);

  //////////////////////////////////////////////////////////////////////
  // Phase sequencing

  always_comb begin
    phase_d = phase_q;
    if (last_t) begin
      case (phase_q)
        sm83_isa_pkg::FETCH: begin
          if (operand_count(decoded_class) != 2'd0) phase_d = sm83_isa_pkg::OPERAND;
          else phase_d = after_operands(decoded_class);
        end
        sm83_isa_pkg::OPERAND: begin
          if (!operand_idx_q && operand_count(op_class_q) == 2'd2) begin
            phase_d = sm83_isa_pkg::OPERAND;
          end else begin
            phase_d = after_operands(op_class_q);
          end
        end
        sm83_isa_pkg::MEMORY: begin
          phase_d = needs_execute(op_class_q) ? sm83_isa_pkg::EXECUTE : sm83_isa_pkg::FETCH;
        end
        default: phase_d = sm83_isa_pkg::FETCH;
      endcase
    end
  end

  always_ff @(posedge i_clk, posedge i_rst) begin
    if (i_rst) begin
      t_state_q     <= '0;
      phase_q       <= sm83_isa_pkg::FETCH;
      opcode_q      <= '0;
      op_class_q    <= sm83_isa_pkg::NOP;
      pc_q          <= RESET_PC;
      operand_idx_q <= 1'b0;
    end else begin
      t_state_q <= last_t ? '0 : t_state_q + 1'b1;
      phase_q   <= phase_d;
      if (last_t && phase_q == sm83_isa_pkg::FETCH) begin
        opcode_q      <= fetched;
        op_class_q    <= decoded_class;
        operand_idx_q <= 1'b0;
        pc_q          <= pc_q + 16'd1;
      end else if (last_t && phase_q == sm83_isa_pkg::OPERAND) begin
        operand_idx_q <= 1'b1;
        pc_q          <= pc_q + 16'd1;
      end
    end
  end

  // Operands arrive low byte first; the (HL) read byte reuses the low slot
  always_ff @(posedge i_clk) begin
    if (last_t && phase_q == sm83_isa_pkg::OPERAND) begin
      if (!operand_idx_q) imm_lo_q <= i_mem_rd_data;
      else imm_hi_q <= i_mem_rd_data;
    end else if (last_t && phase_q == sm83_isa_pkg::MEMORY &&
                 op_class_q == sm83_isa_pkg::LD_R_HL) begin
      imm_lo_q <= i_mem_rd_data;
    end
  end

  assign o_phase      = phase_q;
  assign o_t_state    = t_state_q;
  assign o_opcode     = opcode_q;
  assign o_op_class   = op_class_q;
  assign o_imm        = imm_lo_q;
  assign o_imm16      = {imm_hi_q, imm_lo_q};
  assign o_fetch_addr = pc_q;

  a_memory_only_for_hl: assert property (@(posedge i_clk) disable iff (i_rst)
    (phase_q == sm83_isa_pkg::MEMORY) |-> needs_memory(op_class_q));

  a_tstate_wrap: assert property (@(posedge i_clk) disable iff (i_rst)
    (t_state_q != LAST_T) |=> (t_state_q != '0));

endmodule

`default_nettype wire

// File: source/register_file.sv
`default_nettype none

module register_file (
  input wire logic i_clk,
  input wire logic i_rst,
  regfile_if.regs  io_rf
);

  sm83_bus_pkg::data_t reg_b;
  sm83_bus_pkg::data_t reg_c;
  sm83_bus_pkg::data_t reg_d;
  sm83_bus_pkg::data_t reg_e;
  sm83_bus_pkg::data_t reg_h;
  sm83_bus_pkg::data_t reg_l;
  sm83_bus_pkg::data_t reg_a;

  // Byte view in reg_idx_e order with zero in the HL_MEM slot
  logic [7:0][7:0]     read_view;

  assign read_view       = {reg_a, 8'h00, reg_l, reg_h, reg_e, reg_d, reg_c, reg_b};
  assign io_rf.rd_data_a = read_view[io_rf.rd_sel_a];
  assign io_rf.rd_data_b = read_view[io_rf.rd_sel_b];
  assign io_rf.hl        = {reg_h, reg_l};

  always_ff @(posedge i_clk, posedge i_rst) begin
    if (i_rst) begin
      reg_b <= '0;
      reg_c <= '0;
      reg_d <= '0;
      reg_e <= '0;
      reg_h <= '0;
      reg_l <= '0;
      reg_a <= '0;
    end else if (io_rf.wr_en) begin
      case (io_rf.wr_sel)
        sm83_isa_pkg::B: reg_b <= io_rf.wr_data;
        sm83_isa_pkg::C: reg_c <= io_rf.wr_data;
        sm83_isa_pkg::D: reg_d <= io_rf.wr_data;
        sm83_isa_pkg::E: reg_e <= io_rf.wr_data;
        sm83_isa_pkg::H: reg_h <= io_rf.wr_data;
        sm83_isa_pkg::L: reg_l <= io_rf.wr_data;
        sm83_isa_pkg::A: reg_a <= io_rf.wr_data;
        default: ;
      endcase
    end else if (io_rf.pair_wr_en) begin
      // SP lives outside this core
      case (io_rf.pair_sel)
        sm83_isa_pkg::BC: {reg_b, reg_c} <= io_rf.pair_wr_data;
        sm83_isa_pkg::DE: {reg_d, reg_e} <= io_rf.pair_wr_data;
        sm83_isa_pkg::HL: {reg_h, reg_l} <= io_rf.pair_wr_data;
        default: ;
      endcase
    end
  end

  a_no_mem_target: assert property (@(posedge i_clk) disable iff (i_rst)
    io_rf.wr_en |-> (io_rf.wr_sel != sm83_isa_pkg::HL_MEM));

  a_one_write_port: assert property (@(posedge i_clk) disable iff (i_rst)
    !(io_rf.wr_en && io_rf.pair_wr_en));

endmodule

`default_nettype wire

// File: source/execute_unit.sv
`default_nettype none

module execute_unit (
  input  wire logic                    i_clk,
  input  wire logic                    i_rst,
  input  wire sm83_isa_pkg::phase_e    i_phase,
  input  wire sm83_bus_pkg::tstate_t   i_t_state,
  input  wire sm83_isa_pkg::opcode_u   i_opcode,
  input  wire sm83_isa_pkg::op_class_e i_op_class,
  input  wire sm83_bus_pkg::data_t     i_imm,
  input  wire sm83_bus_pkg::addr_t     i_imm16,
  input  wire sm83_bus_pkg::addr_t     i_fetch_addr,
  regfile_if.execute                   io_rf,
  output sm83_bus_pkg::addr_t          o_mem_rd_addr,
  output logic                         o_mem_wr_en,
  output sm83_bus_pkg::addr_t          o_mem_wr_addr,
  output sm83_bus_pkg::data_t          o_mem_wr_data
);

  localparam sm83_bus_pkg::tstate_t LAST_T = sm83_bus_pkg::tstate_t'(sm83_bus_pkg::T_STATES - 1);

  sm83_bus_pkg::data_t byte_result;
  sm83_bus_pkg::addr_t pair_result;
  sm83_bus_pkg::addr_t pair_value;
  logic                commit;
  logic                is_byte_write;
  logic                is_pair_write;
  logic                is_store;

  //////////////////////////////////////////////////////////////////////
  // Register selection

  // Pair p reads its high byte on port a and low byte on port b
  always_comb begin
    case (i_op_class)
      sm83_isa_pkg::INC_R, sm83_isa_pkg::DEC_R:
        io_rf.rd_sel_a = sm83_isa_pkg::reg_idx_e'(i_opcode.xyz.y);
      sm83_isa_pkg::INC_RR, sm83_isa_pkg::DEC_RR:
        io_rf.rd_sel_a = sm83_isa_pkg::reg_idx_e'({i_opcode.xpqz.p, 1'b0});
      default:
        io_rf.rd_sel_a = sm83_isa_pkg::reg_idx_e'(i_opcode.xyz.z);
    endcase
  end

  assign io_rf.rd_sel_b = sm83_isa_pkg::reg_idx_e'({i_opcode.xpqz.p, 1'b1});
  assign pair_value     = {io_rf.rd_data_a, io_rf.rd_data_b};

  //////////////////////////////////////////////////////////////////////
  // Results and writeback

  always_comb begin
    byte_result = io_rf.rd_data_a;
    pair_result = i_imm16;
    case (i_op_class)
      sm83_isa_pkg::LD_R_N:  byte_result = i_imm;
      sm83_isa_pkg::LD_R_HL: byte_result = i_imm;
      sm83_isa_pkg::INC_R:   byte_result = io_rf.rd_data_a + 8'd1;
      sm83_isa_pkg::DEC_R:   byte_result = io_rf.rd_data_a - 8'd1;
      sm83_isa_pkg::INC_RR:  pair_result = pair_value + 16'd1;
      sm83_isa_pkg::DEC_RR:  pair_result = pair_value - 16'd1;
      default: ;
    endcase
  end

  assign is_byte_write = i_op_class inside {sm83_isa_pkg::LD_R_R, sm83_isa_pkg::LD_R_N,
                                            sm83_isa_pkg::LD_R_HL, sm83_isa_pkg::INC_R,
                                            sm83_isa_pkg::DEC_R};
  assign is_pair_write = i_op_class inside {sm83_isa_pkg::LD_RR_NN, sm83_isa_pkg::INC_RR,
                                            sm83_isa_pkg::DEC_RR};
  assign is_store      = i_op_class inside {sm83_isa_pkg::LD_HL_R, sm83_isa_pkg::LD_HL_N};

  assign commit = (i_phase == sm83_isa_pkg::EXECUTE) && (i_t_state == LAST_T);

  assign io_rf.wr_en        = commit && is_byte_write;
  assign io_rf.wr_sel       = sm83_isa_pkg::reg_idx_e'(i_opcode.xyz.y);
  assign io_rf.wr_data      = byte_result;
  assign io_rf.pair_wr_en   = commit && is_pair_write;
  assign io_rf.pair_sel     = sm83_isa_pkg::pair_idx_e'(i_opcode.xpqz.p);
  assign io_rf.pair_wr_data = pair_result;

  //////////////////////////////////////////////////////////////////////
  // Memory port

  assign o_mem_rd_addr = (i_phase == sm83_isa_pkg::MEMORY) ? io_rf.hl : i_fetch_addr;

  // Registered at T0 so the strobe sits in T1
  always_ff @(posedge i_clk, posedge i_rst) begin
    if (i_rst) begin
      o_mem_wr_en <= 1'b0;
    end else begin
      o_mem_wr_en <= is_store && (i_phase == sm83_isa_pkg::MEMORY) && (i_t_state == '0);
    end
  end

  always_ff @(posedge i_clk) begin
    if (is_store && i_phase == sm83_isa_pkg::MEMORY && i_t_state == '0) begin
      o_mem_wr_addr <= io_rf.hl;
      o_mem_wr_data <= (i_op_class == sm83_isa_pkg::LD_HL_N) ? i_imm : io_rf.rd_data_a;
    end
  end

  a_single_write_strobe: assert property (@(posedge i_clk) disable iff (i_rst)
    o_mem_wr_en |=> !o_mem_wr_en);

endmodule

`default_nettype wire

// File: source/sm83_core.sv
`default_nettype none

module sm83_core #(
  parameter sm83_bus_pkg::addr_t RESET_PC = sm83_bus_pkg::RESET_PC_DEFAULT
) (
  input  wire logic                i_clk,
  input  wire logic                i_rst,
  input  wire sm83_bus_pkg::data_t i_mem_rd_data,
  output sm83_bus_pkg::addr_t      o_mem_rd_addr,
  output logic                     o_mem_wr_en,
  output sm83_bus_pkg::addr_t      o_mem_wr_addr,
  output sm83_bus_pkg::data_t      o_mem_wr_data
);

  sm83_isa_pkg::phase_e    phase;
  sm83_bus_pkg::tstate_t   t_state;
  sm83_isa_pkg::opcode_u   opcode;
  sm83_isa_pkg::op_class_e op_class;
  sm83_bus_pkg::data_t     imm;
  sm83_bus_pkg::addr_t     imm16;
  sm83_bus_pkg::addr_t     fetch_addr;

  regfile_if rf_if ();

  instr_sequencer #(
    .RESET_PC(RESET_PC)
  ) u_instr_sequencer (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_mem_rd_data(i_mem_rd_data),
    .o_phase      (phase),
    .o_t_state    (t_state),
    .o_opcode     (opcode),
    .o_op_class   (op_class),
    .o_imm        (imm),
    .o_imm16      (imm16),
    .o_fetch_addr (fetch_addr)
  );

  register_file u_register_file (
    .i_clk(i_clk),
    .i_rst(i_rst),
    .io_rf(rf_if.regs)
  );

  execute_unit u_execute_unit (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_phase      (phase),
    .i_t_state    (t_state),
    .i_opcode     (opcode),
    .i_op_class   (op_class),
    .i_imm        (imm),
    .i_imm16      (imm16),
    .i_fetch_addr (fetch_addr),
    .io_rf        (rf_if.execute),
    .o_mem_rd_addr(o_mem_rd_addr),
    .o_mem_wr_en  (o_mem_wr_en),
    .o_mem_wr_addr(o_mem_wr_addr),
    .o_mem_wr_data(o_mem_wr_data)
  );

endmodule

`default_nettype wire

// File: verification/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD       = 40,
  parameter int RESET_CYCLES = 5
) (
  input  wire logic i_rst_req,
  output logic      o_clk,
  output logic      o_rst
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD / 2) o_clk = ~o_clk;
  end

  // Reset rises and falls on falling clock edges
  initial begin
    o_rst = 1'b1;
    forever begin
      repeat (RESET_CYCLES) @(posedge o_clk);
      @(negedge o_clk);
      o_rst = 1'b0;
      @(posedge i_rst_req);
      @(negedge o_clk);
      o_rst = 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: verification/tb_sm83_core.sv
`default_nettype none

module tb_sm83_core;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 5;
  localparam int REC_MAX      = 64;
  localparam sm83_bus_pkg::addr_t FIRST_FETCH = 16'h0100;

  // Tag, address, byte count, then up to 16 bytes
  typedef logic [159:0] record_t;

  logic                clk;
  logic                rst;
  logic                rst_req = 1'b0;
  sm83_bus_pkg::data_t mem_rd_data = '0;
  sm83_bus_pkg::addr_t mem_rd_addr;
  logic                mem_wr_en;
  sm83_bus_pkg::addr_t mem_wr_addr;
  sm83_bus_pkg::data_t mem_wr_data;

  sm83_bus_pkg::data_t mem [65536];
  record_t             records [REC_MAX];
  sm83_bus_pkg::addr_t exp_addr_q[$];
  sm83_bus_pkg::data_t exp_data_q[$];
  longint unsigned     watchdog_limit = 0;

  tb_clock_gen #(
    .PERIOD      (CLK_PERIOD),
    .RESET_CYCLES(RESET_CYCLES)
  ) u_clock_gen (
    .i_rst_req(rst_req),
    .o_clk    (clk),
    .o_rst    (rst)
  );

  sm83_core i_sm83_core (
    .i_clk        (clk),
    .i_rst        (rst),
    .i_mem_rd_data(mem_rd_data),
    .o_mem_rd_addr(mem_rd_addr),
    .o_mem_wr_en  (mem_wr_en),
    .o_mem_wr_addr(mem_wr_addr),
    .o_mem_wr_data(mem_wr_data)
  );

  //////////////////////////////////////////////////////////////////////
  // Checks

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Regression failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_addr(input sm83_bus_pkg::addr_t got, input sm83_bus_pkg::addr_t exp,
                            input string what);
    if (got !== exp) abort_run($sformatf("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp));
  endtask

  task automatic check_data(input sm83_bus_pkg::data_t got, input sm83_bus_pkg::data_t exp,
                            input string what);
    if (got !== exp) abort_run($sformatf("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp));
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test data records

  function automatic logic [7:0] tag_of(input record_t rec);
    return rec[159:152];
  endfunction

  function automatic sm83_bus_pkg::addr_t base_of(input record_t rec);
    return rec[151:136];
  endfunction

  function automatic int length_of(input record_t rec);
    return int'(rec[135:128]);
  endfunction

  function automatic sm83_bus_pkg::data_t byte_at(input record_t rec, input int i);
    return rec[127 - 8 * i -: 8];
  endfunction

  task automatic clear_memory();
    foreach (mem[i]) mem[i] = '0;
  endtask

  task automatic load_bytes(input record_t rec);
    sm83_bus_pkg::addr_t a;
    a = base_of(rec);
    for (int i = 0; i < length_of(rec); i++) begin
      mem[a] = byte_at(rec, i);
      a = a + 16'd1;
    end
  endtask

  // All writes of one record go to the same address, in order
  task automatic queue_writes(input record_t rec);
    for (int i = 0; i < length_of(rec); i++) begin
      exp_addr_q.push_back(base_of(rec));
      exp_data_q.push_back(byte_at(rec, i));
    end
  endtask

  task automatic record_write(input sm83_bus_pkg::addr_t addr, input sm83_bus_pkg::data_t data);
    if (exp_addr_q.size() == 0) begin
      abort_run($sformatf("Unexpected memory write of %h to %h at time %0t", data, addr, $time));
    end else begin
      check_addr(addr, exp_addr_q.pop_front(), "write address");
      check_data(data, exp_data_q.pop_front(), "write data");
      mem[addr] = data;
    end
  endtask

  task automatic start_reset();
    @(negedge clk);
    rst_req = 1'b1;
    @(posedge rst);
    rst_req = 1'b0;
  endtask

  // Runs until the fetch address passes the last program byte
  task automatic run_program(input sm83_bus_pkg::addr_t end_addr);
    @(negedge rst);
    check_addr(mem_rd_addr, FIRST_FETCH, "first fetch address");
    if (mem_wr_en !== 1'b0) abort_run("Memory write strobe is active right after reset");
    do begin
      @(negedge clk);
    end while (mem_rd_addr !== end_addr);
    if (exp_addr_q.size() != 0) begin
      abort_run($sformatf("%0d expected memory writes never happened", exp_addr_q.size()));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Memory model

  always @(negedge clk) begin
    if (mem_wr_en === 1'b1) record_write(mem_wr_addr, mem_wr_data);
    mem_rd_data <= mem[mem_rd_addr];
  end

  initial begin
    wait (watchdog_limit != 0);
    #(watchdog_limit);
    abort_run("Watchdog expired before the tests finished");
  end

  initial begin
    int      idx;
    int      num_tests;
    int      total_instr;
    record_t rec;
    num_tests   = 0;
    total_instr = 0;
    clear_memory();
    $readmemh("verification/sm83_testdata.txt", records);
    for (idx = 0; idx < REC_MAX; idx++) begin
      if ($isunknown(tag_of(records[idx]))) abort_run("Test data file is missing or malformed");
      if (tag_of(records[idx]) == 8'hff) break;
      if (tag_of(records[idx]) == 8'h04) begin
        num_tests++;
        total_instr += length_of(records[idx]);
      end
    end
    if (idx == REC_MAX || num_tests == 0) abort_run("Test data holds no complete test");
    // Worst case of 4 M-cycles per instruction
    watchdog_limit = longint'(total_instr) * 4 * sm83_bus_pkg::T_STATES * CLK_PERIOD
                   + longint'(num_tests) * (RESET_CYCLES + 3) * CLK_PERIOD + 50 * CLK_PERIOD;
    for (idx = 0; tag_of(records[idx]) != 8'hff; idx++) begin
      rec = records[idx];
      case (tag_of(rec))
        8'h01, 8'h02: load_bytes(rec);
        8'h03: queue_writes(rec);
        8'h04: begin
          run_program(base_of(rec));
          start_reset();
          clear_memory();
        end
        default: abort_run($sformatf("Unknown record tag %h in test data", tag_of(rec)));
      endcase
    end
    $display("%0d tests with %0d instructions done", num_tests, total_instr);
    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/sm83_testdata.txt
// tag_addr_count_bytes: 01 program bytes, 02 preload bytes, 03 writes expected in order at addr
// 04 run until fetch reaches addr (count = instructions), ff end of data
01_0100_10_21_00_c0_06_11_0e_22_16_33_1e_44_3e_55_70_71_72
01_0110_0a_73_77_74_75_2e_08_75_26_c2_74_00_00_00_00_00_00
03_c000_07_11_22_33_44_55_c0_00_00_00_00_00_00_00_00_00_00
03_c008_01_08_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00
03_c208_01_c2_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00
04_011a_11_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00
01_0100_10_21_00_d0_3e_ff_4f_0c_71_57_3d_77_1e_00_1d_73_7a
01_0110_02_3c_77_00_00_00_00_00_00_00_00_00_00_00_00_00_00
03_d000_04_00_fe_ff_00_00_00_00_00_00_00_00_00_00_00_00_00
04_0112_0e_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00
01_0100_10_21_00_e0_01_ff_00_03_70_71_11_00_00_1b_72_73_21
01_0110_08_ff_ff_23_77_2b_74_2b_75_00_00_00_00_00_00_00_00
03_e000_04_01_00_ff_ff_00_00_00_00_00_00_00_00_00_00_00_00
03_0000_01_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00
03_ffff_01_ff_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00
03_fffe_01_fe_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00
04_0118_10_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00
01_0100_0d_21_10_c0_46_26_c8_70_36_3c_7e_2e_11_77_00_00_00
02_c010_01_a7_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00
03_c810_02_a7_3c_00_00_00_00_00_00_00_00_00_00_00_00_00_00
03_c811_01_3c_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00
04_010d_08_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00
01_0100_10_21_20_c0_3e_99_77_00_31_00_00_33_3b_34_35_22_02
01_0110_08_f0_00_ea_00_00_76_3c_77_00_00_00_00_00_00_00_00
03_c020_02_99_9a_00_00_00_00_00_00_00_00_00_00_00_00_00_00
04_0118_15_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00
ff_0000_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00

// File: project.f
source/sm83_isa_pkg.sv
source/sm83_bus_pkg.sv
source/regfile_if.sv
source/instr_sequencer.sv
source/register_file.sv
source/execute_unit.sv
source/sm83_core.sv
verification/tb_clock_gen.sv
verification/tb_sm83_core.sv

// File: Bender.yml
package:
  name: sm83_core

sources:
  - source/sm83_isa_pkg.sv
  - source/sm83_bus_pkg.sv
  - source/regfile_if.sv
  - source/instr_sequencer.sv
  - source/register_file.sv
  - source/execute_unit.sv
  - source/sm83_core.sv
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/tb_sm83_core.sv
